// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ucode_ctrl
RTL_TOP  = ucode_ctrl
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: include/ucode_table.svh
// include inside a module body after importing ucode_pkg; rows not listed are all zero
// reset routine: vector on intvec while pc loads
function automatic ctrl_t ucode_row(input logic [UCODE_AW-1:0] addr);
    ctrl_t row;
    case (addr)
        {RESET, 2'd0}: row = '{int_en: 1'b1, default: 1'b0};
        {RESET, 2'd1}: row = '{int_en: 1'b1, up_ld16: 1'b1, default: 1'b0};
        {RESET, 2'd2}: row = '{ni: 1'b1, default: 1'b0};

        // nmi and firq mask both sources
        {NMI, 2'd0},
        {FIRQ, 2'd0},
        {IRQ, 2'd0}:   row = '{psh_go: 1'b1, default: 1'b0};  // stack the machine state
        {NMI, 2'd1},
        {FIRQ, 2'd1}:  row = '{int_en: 1'b1, set_i: 1'b1, set_f: 1'b1, default: 1'b0};
        {IRQ, 2'd1}:   row = '{int_en: 1'b1, set_i: 1'b1, default: 1'b0};
        {NMI, 2'd2},
        {FIRQ, 2'd2},
        {IRQ, 2'd2}:   row = '{int_en: 1'b1, up_ld16: 1'b1, default: 1'b0};
        {NMI, 2'd3},
        {FIRQ, 2'd3},
        {IRQ, 2'd3}:   row = '{ni: 1'b1, default: 1'b0};

        {ALU8_IMM, 2'd0}:  row = '{alu_go: 1'b1, default: 1'b0};
        {ALU8_IMM, 2'd1}:  row = '{up_ld8: 1'b1, ni: 1'b1, default: 1'b0};
        {ALU16_IMM, 2'd0}: row = '{alu_go: 1'b1, default: 1'b0};
        {ALU16_IMM, 2'd1}: row = '{up_ld16: 1'b1, default: 1'b0};
        {ALU16_IMM, 2'd2}: row = '{ni: 1'b1, default: 1'b0};
        {INH_A, 2'd0}:     row = '{alu_go: 1'b1, up_ld8: 1'b1, ni: 1'b1, default: 1'b0};

        // postbyte already on mdata
        {PARSE_IDX, 2'd0}: row = '{idx_jmp: 1'b1, default: 1'b0};

        {ALU8_IDX, 2'd0}:   row = '{alu_go: 1'b1, default: 1'b0};
        {ALU8_IDX, 2'd1}:   row = '{up_ld8: 1'b1, ni: 1'b1, default: 1'b0};
        {STORE8_IDX, 2'd0}: row = '{we: 1'b1, default: 1'b0};
        {STORE8_IDX, 2'd1}: row = '{ni: 1'b1, default: 1'b0};
        {JUMP_IDX, 2'd0}:   row = '{up_ld16: 1'b1, ni: 1'b1, default: 1'b0};

        // target byte sits on op after the pc load, so redispatch at once
        {BRANCH, 2'd0}: row = '{alu_go: 1'b1, default: 1'b0};
        {BRANCH, 2'd1}: row = '{up_ld16: 1'b1, uc_loop: 1'b1, default: 1'b0};

        {NOPE, 2'd0}: row = '0;  // idle cycle
        {NOPE, 2'd1}: row = '{ni: 1'b1, default: 1'b0};

        // effective address, then indirect fetch or follow-on
        {IDX_OFFSET, 2'd0}: row = '{alu_go: 1'b1, set_idx_post: 1'b1, default: 1'b0};
        {IDX_OFFSET, 2'd1}: row = '{idx_ind: 1'b1, default: 1'b0};
        {IDX_IND, 2'd0}:    row = '{up_ld16: 1'b1, default: 1'b0};
        {IDX_IND, 2'd1}:    row = '{idx_ret: 1'b1, default: 1'b0};

        default: row = '0;  // bus error rows and unused slots
    endcase
    return row;
endfunction

// File: project.f
+incdir+include
verilog/ucode_pkg.sv
verilog/op_classifier.sv
verilog/idx_decoder.sv
verilog/int_arbiter.sv
verilog/ucode_sequencer.sv
verilog/ucode_ctrl.sv
testbench/ucode_model.sv
testbench/tb_ucode_ctrl.sv

// File: testbench/tb_ucode_ctrl.sv
// random regression against ucode_model with a fixed seed; the run stops at MAX_CYCLES cycles
module tb_ucode_ctrl;
    import ucode_pkg::*;

    localparam int MAX_CYCLES = 3000;  // six tests of at most 400 cycles, plus margin

    logic       clk = 1'b0;
    logic       rst;
    logic       cen;
    op_t        op;
    logic [15:0] mdata;
    logic [7:0] cc;
    logic       mem_busy;
    logic       stack_busy;
    logic       nmi_n;
    logic       firq_n;
    logic       irq_n;
    ctrl_t      ctrl;
    ctrl_t      exp_ctrl;
    idx_sel_t   idx_sel;
    idx_sel_t   exp_idx_sel;
    logic [3:0] intvec;
    logic [3:0] exp_intvec;
    logic       intsrv;
    logic       exp_intsrv;
    logic       buserror;
    logic       exp_buserror;

    int    cycles = 0;
    int    test_errs;
    int    n_pass = 0;
    int    n_fail = 0;
    string test_name;

    op_t        plain_ops[18] = '{LDA_IMM, LDB_IMM, ADDA_IMM, ADDB_IMM, SUBA_IMM, ANDA_IMM,
                                  LDD_IMM, LDX_IMM, ADDD_IMM, CLRA, INCA, DECA, NEGA, COMA,
                                  BRA, BNE, BEQ, NOP};
    op_t        idx_ops[6]    = '{LDA_IDX, ADDA_IDX, ANDA_IDX, STA, STB, JMP};
    logic [3:0] idx_modes[6]  = '{4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hf};  // {bit 7, bits 2:0}

    ucode_ctrl u_ucode_ctrl (.*);

    ucode_model u_ucode_model (
        .clk(clk), .rst(rst), .cen(cen), .op(op), .postbyte(mdata[7:0]), .cc(cc),
        .busy(mem_busy || stack_busy), .nmi_n(nmi_n), .firq_n(firq_n), .irq_n(irq_n),
        .ctrl(exp_ctrl), .idx_sel(exp_idx_sel), .intvec(exp_intvec),
        .intsrv(exp_intsrv), .buserror(exp_buserror)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [7:0] valid_postbyte();
        logic [3:0] mode;
        logic [7:0] pb;
        mode = idx_modes[3'($urandom % 6)];
        pb   = 8'($urandom);
        return {mode[3], pb[6:3], mode[2:0]};
    endfunction

    task automatic report_value(string what, logic [31:0] exp, logic [31:0] act);
        test_errs++;
        $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic compare_outputs();
        if (ctrl !== exp_ctrl) report_value("ctrl", 32'(exp_ctrl), 32'(ctrl));
        if (idx_sel !== exp_idx_sel) report_value("idx_sel", 32'(exp_idx_sel), 32'(idx_sel));
        if (intvec !== exp_intvec) report_value("intvec", 32'(exp_intvec), 32'(intvec));
        if (intsrv !== exp_intsrv) report_value("intsrv", 32'(exp_intsrv), 32'(intsrv));
        if (buserror !== exp_buserror) report_value("buserror", 32'(exp_buserror), 32'(buserror));
    endtask

    // ends on the falling edge that releases reset
    task automatic apply_reset();
        rst        = 1'b1;
        cen        = 1'b1;
        op         = NOP;
        mdata      = '0;
        cc         = 8'h50;  // I and F set
        mem_busy   = 1'b0;
        stack_busy = 1'b0;
        nmi_n      = 1'b1;
        firq_n     = 1'b1;
        irq_n      = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errs = 0;
        apply_reset();
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("PASS %s", test_name);
        end else begin
            n_fail++;
            $display("FAIL %s with %0d mismatches", test_name, test_errs);
        end
    endtask

    // mode 0 plain opcodes, 1 indexed opcodes, 2 everything with interrupts
    task automatic drive_random(int mode);
        cen        = ($urandom % 8) != 0;
        mem_busy   = ($urandom % 4) == 0;
        stack_busy = ($urandom % 6) == 0;
        cc         = 8'($urandom);
        mdata      = {8'($urandom), valid_postbyte()};
        if (mode == 1 || (mode == 2 && ($urandom % 3) == 0))
            op = idx_ops[3'($urandom % 6)];
        else
            op = plain_ops[5'($urandom % 18)];
        if (mode == 2) begin
            if (($urandom % 5) == 0) nmi_n = ~nmi_n;
            firq_n = ($urandom % 3) != 0;
            irq_n  = ($urandom % 2) != 0;
        end
    endtask

    task automatic run_random(string name, int mode, int n);
        begin_test(name);
        repeat (n) begin
            drive_random(mode);
            @(negedge clk);
            compare_outputs();
        end
        end_test();
    endtask

    task automatic run_bus_error(string name, logic bad_op);
        logic [25:0] snap;
        int          waited;
        begin_test(name);
        waited = 0;
        op     = bad_op ? (8'hf0 | 8'($urandom % 16)) : idx_ops[3'($urandom % 6)];
        mdata  = {8'h00, 1'b0, 4'($urandom), 3'b000};  // unused postbyte code
        while (!buserror && waited < 60) begin
            @(negedge clk);
            compare_outputs();
            waited++;
        end
        if (!buserror) begin
            test_errs++;
            $display("%s: buserror did not rise within %0d cycles", name, waited);
        end else begin
            snap = {ctrl, idx_sel, intvec, intsrv, buserror};
            repeat (40) begin
                drive_random(0);
                if (($urandom % 4) == 0) nmi_n = ~nmi_n;  // latch is frozen too
                @(negedge clk);
                compare_outputs();
                if ({ctrl, idx_sel, intvec, intsrv, buserror} !== snap)
                    report_value("frozen", 32'(snap), 32'({ctrl, idx_sel, intvec, intsrv, buserror}));
            end
        end
        end_test();
    endtask

    initial begin
        ctrl_t reset_row;
        reset_row = '{int_en: 1'b1, default: 1'b0};
        void'($urandom(32'h723c));

        begin_test("reset_state");
        compare_outputs();
        if (intvec !== VEC_RESET) report_value("intvec", 32'(VEC_RESET), 32'(intvec));
        if (ctrl !== reset_row) report_value("ctrl", 32'(reset_row), 32'(ctrl));
        if (idx_sel !== '0) report_value("idx_sel", 32'd0, 32'(idx_sel));
        if (buserror !== 1'b0) report_value("buserror", 32'd0, 32'(buserror));
        end_test();

        run_random("plain_dispatch", 0, 300);
        run_random("indexed_path", 1, 300);
        run_random("int_priority", 2, 400);
        run_bus_error("bad_opcode", 1'b1);
        run_bus_error("bad_postbyte", 1'b0);

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: testbench/ucode_model.sv
// cycle model of the sequencer and arbiter; only the microcode table is shared with the design
module ucode_model (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  ucode_pkg::op_t      op,
    input  logic [7:0]          postbyte,
    input  logic [7:0]          cc,
    input  logic                busy,      // mem or stack busy
    input  logic                nmi_n,
    input  logic                firq_n,
    input  logic                irq_n,
    output ucode_pkg::ctrl_t    ctrl,
    output ucode_pkg::idx_sel_t idx_sel,
    output logic [3:0]          intvec,
    output logic                intsrv,
    output logic                buserror
);
    import ucode_pkg::*;

    `include "ucode_table.svh"

    logic [UCODE_AW-1:0] upc;
    logic [UCODE_AW-1:0] upc_nx;
    cat_t                follow;    // follow-on routine
    cat_t                win_cat;
    logic [3:0]          win_vec;
    logic [3:0]          vec;
    logic                nmi_last;
    logic                nmi_flag;
    logic                firq_on;
    logic                irq_on;
    logic                take;      // ni dispatch this cycle

    function automatic cat_t op_routine(op_t o);
        if (o inside {LDA_IMM, LDB_IMM, ADDA_IMM, ADDB_IMM, SUBA_IMM, ANDA_IMM}) return ALU8_IMM;
        if (o inside {LDD_IMM, LDX_IMM, ADDD_IMM}) return ALU16_IMM;
        if (o inside {CLRA, INCA, DECA, NEGA, COMA}) return INH_A;
        if (o inside {LDA_IDX, ADDA_IDX, ANDA_IDX, STA, STB, JMP}) return PARSE_IDX;
        if (o inside {BRA, BNE, BEQ}) return BRANCH;
        if (o == NOP) return NOPE;
        return BUSERROR;
    endfunction

    function automatic cat_t follow_on(op_t o, cat_t held);
        if (o inside {LDA_IDX, ADDA_IDX, ANDA_IDX}) return ALU8_IDX;
        if (o inside {STA, STB}) return STORE8_IDX;
        if (o == JMP) return JUMP_IDX;
        return held;
    endfunction

    function automatic cat_t postbyte_routine(logic [7:0] pb);
        logic [3:0] mode;
        mode = {pb[7], pb[2:0]};
        if (mode inside {4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hf}) return IDX_OFFSET;
        return BUSERROR;
    endfunction

    assign ctrl     = ucode_row(upc);
    assign buserror = upc == {BUSERROR, 2'b00};
    assign firq_on  = !firq_n && !cc[CC_F];
    assign irq_on   = !irq_n && !cc[CC_I];
    assign intsrv   = nmi_flag || firq_on || irq_on;
    assign intvec   = ctrl.int_en ? vec : VEC_NONE;
    assign take     = ctrl.ni && !(ctrl.idx_ret || ctrl.idx_ind || ctrl.idx_jmp || ctrl.uc_loop);

    always_comb begin
        if (nmi_flag) begin
            win_cat = NMI;
            win_vec = VEC_NMI;
        end else if (firq_on) begin
            win_cat = FIRQ;
            win_vec = VEC_FIRQ;
        end else if (irq_on) begin
            win_cat = IRQ;
            win_vec = VEC_IRQ;
        end else begin
            win_cat = op_routine(op);
            win_vec = VEC_NONE;
        end
    end

    always_comb begin
        if (ctrl.idx_ret)
            upc_nx = {follow, 2'b00};
        else if (ctrl.idx_ind)
            upc_nx = {idx_sel.indirect ? IDX_IND : follow, 2'b00};
        else if (ctrl.idx_jmp)
            upc_nx = {postbyte_routine(postbyte), 2'b00};
        else if (ctrl.uc_loop)
            upc_nx = {op_routine(op), 2'b00};
        else if (ctrl.ni)
            upc_nx = {win_cat, 2'b00};
        else if (busy)
            upc_nx = upc;
        else
            upc_nx = upc + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upc      <= {RESET, 2'b00};
            follow   <= RESET;
            idx_sel  <= '0;
            vec      <= VEC_RESET;
            nmi_last <= 1'b0;
            nmi_flag <= 1'b0;
        end else if (cen && !buserror) begin
            upc      <= upc_nx;
            follow   <= follow_on(op, follow);
            nmi_last <= nmi_n;
            nmi_flag <= (nmi_last && !nmi_n) || (nmi_flag && !take);
            if (take)
                vec <= win_vec;
            if (ctrl.idx_ret)
                idx_sel.indirect <= 1'b0;
            else if (ctrl.idx_jmp)
                idx_sel <= '{reg_sel: postbyte[6:4], acc_sel: postbyte[1:0], indirect: postbyte[3]};
        end
    end

endmodule

// File: verilog/idx_decoder.sv
// only offset-style postbytes are decoded; every other code leads to BUSERROR
module idx_decoder (
    input  logic [7:0]          postbyte,
    output ucode_pkg::cat_t     idx_cat,
    output ucode_pkg::idx_sel_t idx_sel
);
    import ucode_pkg::*;

    // bit 7 and bits 2:0 pick the addressing mode
    always_comb begin
        case ({postbyte[7], postbyte[2:0]})
            4'b0_100,                    // 8-bit offset
            4'b0_101,                    // 16-bit offset
            4'b0_110: begin              // register, no offset
                idx_cat = IDX_OFFSET;
            end
            4'b1_000,
            4'b1_001,
            4'b1_111: begin              // accumulator offsets
                idx_cat = IDX_OFFSET;
            end
            default: begin
                idx_cat = BUSERROR;
            end
        endcase
    end

    assign idx_sel = '{
        reg_sel:  postbyte[6:4],
        acc_sel:  postbyte[1:0],
        indirect: postbyte[3]
    };

endmodule

// File: verilog/int_arbiter.sv
// nmi_n is sampled on enabled cycles only; firq_n and irq_n are levels held until served
module int_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  logic            halt,      // bus error stop
    input  logic            nmi_n,
    input  logic            firq_n,
    input  logic            irq_n,
    input  logic [7:0]      cc,
    input  logic            dispatch,  // sequencer enters a new routine
    input  logic            int_en,
    output logic            int_pending,
    output ucode_pkg::cat_t int_cat,
    output logic            intsrv,
    output logic [3:0]      intvec
);
    import ucode_pkg::*;

    logic       nmi_n_l;
    logic       nmi_pend;
    logic       nmi_fall;
    logic       firq_req;
    logic       irq_req;
    logic [3:0] cur_int;
    logic [3:0] vec_nx;

    assign nmi_fall = nmi_n_l && !nmi_n;
    assign firq_req = !firq_n && !cc[CC_F];
    assign irq_req  = !irq_n && !cc[CC_I];

    // nmi > firq > irq
    always_comb begin
        if (nmi_pend) begin
            int_cat = NMI;
            vec_nx  = VEC_NMI;
        end else if (firq_req) begin
            int_cat = FIRQ;
            vec_nx  = VEC_FIRQ;
        end else if (irq_req) begin
            int_cat = IRQ;
            vec_nx  = VEC_IRQ;
        end else begin
            int_cat = IRQ;  // not looked at, int_pending is low
            vec_nx  = VEC_NONE;
        end
    end

    assign int_pending = nmi_pend || firq_req || irq_req;
    assign intsrv      = int_pending;
    assign intvec      = cur_int & {4{int_en}};

    always_ff @(posedge clk) begin
        if (rst) begin
            nmi_n_l  <= 1'b0;  // low nmi_n during reset is not an edge
            nmi_pend <= 1'b0;
            cur_int  <= VEC_RESET;
        end else if (cen && !halt) begin
            nmi_n_l  <= nmi_n;
            nmi_pend <= nmi_fall || (nmi_pend && !dispatch);
            if (dispatch) begin
                cur_int <= vec_nx;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(cur_int));

endmodule

// File: verilog/op_classifier.sv
// opcodes outside the reduced set map to BUSERROR; non-indexed opcodes pass the follow-on through
module op_classifier (
    input  ucode_pkg::op_t  op,
    input  ucode_pkg::cat_t latched_next,  // follow-on held by the sequencer
    output ucode_pkg::cat_t cat,
    output ucode_pkg::cat_t next_cat
);
    import ucode_pkg::*;

    always_comb begin
        next_cat = latched_next;  // kept unless an indexed form names a new one
        case (op)
            LDA_IMM, LDB_IMM, ADDA_IMM,
            ADDB_IMM, SUBA_IMM, ANDA_IMM: begin
                cat = ALU8_IMM;
            end

            LDD_IMM, LDX_IMM, ADDD_IMM: begin
                cat = ALU16_IMM;
            end

            CLRA, INCA, DECA, NEGA, COMA: begin
                cat = INH_A;
            end

            // indexed forms parse the postbyte first
            LDA_IDX, ADDA_IDX, ANDA_IDX: begin
                cat      = PARSE_IDX;
                next_cat = ALU8_IDX;
            end

            STA, STB: begin
                cat      = PARSE_IDX;
                next_cat = STORE8_IDX;
            end

            JMP: begin
                cat      = PARSE_IDX;
                next_cat = JUMP_IDX;
            end

            BRA, BNE, BEQ: begin
                cat = BRANCH;
            end

            NOP: begin
                cat = NOPE;
            end

            default: begin
                cat = BUSERROR;  // stops the core
            end
        endcase
    end

endmodule

// File: verilog/ucode_ctrl.sv
// no datapath here; only mdata[7:0] is read, as the indexed postbyte
module ucode_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  ucode_pkg::op_t      op,
    input  logic [15:0]         mdata,
    input  logic [7:0]          cc,
    input  logic                mem_busy,
    input  logic                stack_busy,
    input  logic                nmi_n,
    input  logic                firq_n,
    input  logic                irq_n,
    output ucode_pkg::ctrl_t    ctrl,
    output ucode_pkg::idx_sel_t idx_sel,
    output logic [3:0]          intvec,
    output logic                intsrv,
    output logic                buserror
);
    import ucode_pkg::*;

    cat_t     cat;
    cat_t     next_cat;
    cat_t     latched_next;
    cat_t     idx_cat;
    cat_t     int_cat;
    idx_sel_t idx_dec_sel;  // straight from the postbyte
    logic     int_pending;
    logic     dispatch;

    op_classifier u_op_classifier (
        .op           (op),
        .latched_next (latched_next),
        .cat          (cat),
        .next_cat     (next_cat)
    );

    idx_decoder u_idx_decoder (
        .postbyte (mdata[7:0]),
        .idx_cat  (idx_cat),
        .idx_sel  (idx_dec_sel)
    );

    int_arbiter u_int_arbiter (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .halt        (buserror),
        .nmi_n       (nmi_n),
        .firq_n      (firq_n),
        .irq_n       (irq_n),
        .cc          (cc),
        .dispatch    (dispatch),
        .int_en      (ctrl.int_en),
        .int_pending (int_pending),
        .int_cat     (int_cat),
        .intsrv      (intsrv),
        .intvec      (intvec)
    );

    ucode_sequencer u_ucode_sequencer (
        .clk          (clk),
        .rst          (rst),
        .cen          (cen),
        .mem_busy     (mem_busy),
        .stack_busy   (stack_busy),
        .cat          (cat),
        .next_cat     (next_cat),
        .idx_cat      (idx_cat),
        .idx_sel_in   (idx_dec_sel),
        .int_pending  (int_pending),
        .int_cat      (int_cat),
        .dispatch     (dispatch),
        .latched_next (latched_next),
        .ctrl         (ctrl),
        .idx_sel      (idx_sel),
        .buserror     (buserror)
    );

endmodule

// File: verilog/ucode_pkg.sv
// reduced opcode map of 24 entries, so opcode values here are not a full 6809-family map
package ucode_pkg;

    localparam int UCODE_AW = 6;    // 64 microcode rows
    localparam int ROW_AW   = 2;    // four rows per routine
    localparam int CC_I     = 4;    // irq mask bit in cc
    localparam int CC_F     = 6;    // firq mask bit in cc

    typedef logic [7:0] op_t;

    // routine categories, the upper bits of the micro-address
    typedef enum logic [3:0] {
        RESET      = 4'd0,
        NMI        = 4'd1,
        FIRQ       = 4'd2,
        IRQ        = 4'd3,
        ALU8_IMM   = 4'd4,
        ALU16_IMM  = 4'd5,
        INH_A      = 4'd6,
        PARSE_IDX  = 4'd7,
        ALU8_IDX   = 4'd8,
        STORE8_IDX = 4'd9,
        JUMP_IDX   = 4'd10,
        BRANCH     = 4'd11,
        NOPE       = 4'd12,
        IDX_OFFSET = 4'd13,
        IDX_IND    = 4'd14,
        BUSERROR   = 4'd15
    } cat_t;

    typedef struct packed {
        logic ni;            // next instruction
        logic uc_loop;       // redispatch on current opcode
        logic idx_jmp;       // dispatch on postbyte
        logic idx_ind;       // leave index routine
        logic idx_ret;       // back from indirect fetch
        logic set_idx_post;  // post-modify request
        logic we;
        logic up_ld8;
        logic up_ld16;
        logic alu_go;
        logic psh_go;
        logic int_en;        // put current vector on intvec
        logic set_i;
        logic set_f;
    } ctrl_t;

    typedef struct packed {
        logic [2:0] reg_sel;
        logic [1:0] acc_sel;
        logic       indirect;
    } idx_sel_t;

    // interrupt vectors, one-hot
    localparam logic [3:0] VEC_RESET = 4'b1000;
    localparam logic [3:0] VEC_NMI   = 4'b0100;
    localparam logic [3:0] VEC_FIRQ  = 4'b0010;
    localparam logic [3:0] VEC_IRQ   = 4'b0001;
    localparam logic [3:0] VEC_NONE  = 4'b0000;

    localparam op_t LDA_IMM  = 8'h10;
    localparam op_t LDA_IDX  = 8'h11;
    localparam op_t LDB_IMM  = 8'h12;
    localparam op_t ADDA_IMM = 8'h14;
    localparam op_t ADDA_IDX = 8'h15;
    localparam op_t ADDB_IMM = 8'h16;
    localparam op_t SUBA_IMM = 8'h18;
    localparam op_t ANDA_IMM = 8'h1c;
    localparam op_t ANDA_IDX = 8'h1d;
    localparam op_t LDD_IMM  = 8'h28;
    localparam op_t LDX_IMM  = 8'h2a;
    localparam op_t ADDD_IMM = 8'h2c;
    localparam op_t STA      = 8'h3a;
    localparam op_t STB      = 8'h3b;
    localparam op_t CLRA     = 8'h42;
    localparam op_t INCA     = 8'h44;
    localparam op_t DECA     = 8'h46;
    localparam op_t NEGA     = 8'h48;
    localparam op_t COMA     = 8'h4a;
    localparam op_t JMP      = 8'h6e;
    localparam op_t BRA      = 8'h80;
    localparam op_t BNE      = 8'h84;
    localparam op_t BEQ      = 8'h86;
    localparam op_t NOP      = 8'hb3;

    // first row of a routine
    function automatic logic [UCODE_AW-1:0] row0(cat_t c);
        return {c, {ROW_AW{1'b0}}};
    endfunction

endpackage

// File: verilog/ucode_sequencer.sv
// busy stalls only the plain advance; dispatch and redirecting rows go ahead regardless
module ucode_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                mem_busy,
    input  logic                stack_busy,
    input  ucode_pkg::cat_t     cat,          // category of op
    input  ucode_pkg::cat_t     next_cat,
    input  ucode_pkg::cat_t     idx_cat,
    input  ucode_pkg::idx_sel_t idx_sel_in,
    input  logic                int_pending,
    input  ucode_pkg::cat_t     int_cat,
    output logic                dispatch,
    output ucode_pkg::cat_t     latched_next,  // follow-on routine
    output ucode_pkg::ctrl_t    ctrl,
    output ucode_pkg::idx_sel_t idx_sel,
    output logic                buserror
);
    import ucode_pkg::*;

    `include "ucode_table.svh"

    logic [UCODE_AW-1:0] addr;
    logic [UCODE_AW-1:0] addr_nx;
    logic                busy;
    logic                redirect;

    assign ctrl     = ucode_row(addr);
    assign busy     = mem_busy || stack_busy;
    assign redirect = ctrl.idx_ret || ctrl.idx_ind || ctrl.idx_jmp || ctrl.uc_loop;

    // frozen on the first bus error row until reset
    assign buserror = addr == row0(BUSERROR);
    assign dispatch = cen && !buserror && ctrl.ni && !redirect;

    // idx_ret > idx_ind > idx_jmp > uc_loop > ni > advance
    always_comb begin
        if (ctrl.idx_ret) begin
            addr_nx = row0(latched_next);
        end else if (ctrl.idx_ind) begin
            addr_nx = idx_sel.indirect ? row0(IDX_IND) : row0(latched_next);
        end else if (ctrl.idx_jmp) begin
            addr_nx = row0(idx_cat);
        end else if (ctrl.uc_loop) begin
            addr_nx = row0(cat);
        end else if (ctrl.ni) begin
            addr_nx = int_pending ? row0(int_cat) : row0(cat);
        end else if (busy) begin
            addr_nx = addr;  // hold the row
        end else begin
            addr_nx = addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr         <= row0(RESET);
            latched_next <= RESET;
            idx_sel      <= '0;
        end else if (cen && !buserror) begin
            addr         <= addr_nx;
            latched_next <= next_cat;  // classifier passes it through for plain opcodes
            if (ctrl.idx_ret) begin
                idx_sel.indirect <= 1'b0;  // indirect fetch done
            end else if (ctrl.idx_jmp) begin
                idx_sel <= idx_sel_in;
            end
        end
    end

    // a row never both enters and leaves the index flow
    assert property (@(posedge clk) disable iff (rst) !(ctrl.idx_jmp && ctrl.idx_ret));

    // stalled rows keep their address into the next cycle
    assert property (@(posedge clk) disable iff (rst)
        busy && !redirect && !ctrl.ni |=> $stable(addr));

endmodule
